// File: hw/pam_geom_pkg.sv
// ==============================
// geometry of the page allocation map, one bit per page, set means in use
// the map is two equal banks of 64-bit words, low bank first
// widths below must stay consistent with each other by hand
// ==============================

package pam_geom_pkg;

	// width of a full page number across both banks
	localparam int PAGE_BITS = 14;

	// bits held in one map word
	localparam int WORD_BITS = 64;

	// width of the bit position inside one map word
	localparam int BIT_IDX_BITS = 6;

	// words per bank, a power of two so the word counter wraps at the end
	localparam int BANK_WORDS = 128;

	// width of the word index inside one bank
	localparam int WORD_IDX_BITS = 7;

	// pages per bank, sized to the page number so it adds without extension
	localparam logic [PAGE_BITS-1:0] BANK_PAGES = 14'd8192;

endpackage

// File: hw/pam_ctrl_pkg.sv
// ==============================
// control types shared by the selector and the two banks
// encodings are fixed widths so they can be probed from outside
// ==============================

package pam_ctrl_pkg;

	// command latched by the selector while busy
	// OP_NONE means nothing is in flight
	typedef enum logic [1:0]
	{
		OP_NONE,
		OP_ALLOC,
		OP_FREE,
		OP_CLEAR
	} pam_op_e;

	// bank state machine
	// BS_HOLD keeps a search result until the selector commits or drops it
	// BS_FREE_RD is the read half of the free read-modify-write
	typedef enum logic [2:0]
	{
		BS_CLEAR,
		BS_IDLE,
		BS_SEARCH,
		BS_HOLD,
		BS_WRITE,
		BS_FREE_RD
	} bank_state_e;

endpackage

// File: hw/pam_bank.sv
// ==============================
// one bank of 128 map words, orders are accepted only in BS_IDLE
// map contents are undefined after reset until the first clear
// the map is read asynchronously, so it maps to distributed RAM
// ==============================

module pam_bank
(
	input  logic clk,
	input  logic rst,
	input  logic clear_i,
	input  logic search_i,
	input  logic commit_i,
	input  logic hold_release_i,
	input  logic free_i,
	input  logic [pam_geom_pkg::WORD_IDX_BITS+pam_geom_pkg::BIT_IDX_BITS-1:0] free_idx_i,
	output logic ready_o,
	output logic found_o,
	output logic [pam_geom_pkg::WORD_IDX_BITS+pam_geom_pkg::BIT_IDX_BITS-1:0] idx_o
);

	pam_ctrl_pkg::bank_state_e state;

	// the map itself, one bit per page of this bank
	logic [pam_geom_pkg::WORD_BITS-1:0] map_mem [pam_geom_pkg::BANK_WORDS];

	// word being scanned, cleared or rewritten
	logic [pam_geom_pkg::WORD_IDX_BITS-1:0] word_idx;
	// bit chosen by a search or named by a free
	logic [pam_geom_pkg::BIT_IDX_BITS-1:0] bit_idx;
	// copy of the word that is about to be written back
	logic [pam_geom_pkg::WORD_BITS-1:0] work;

	logic [pam_geom_pkg::WORD_BITS-1:0] rd_word;
	logic [pam_geom_pkg::WORD_BITS-1:0] bit_mask;
	logic [pam_geom_pkg::BIT_IDX_BITS-1:0] zero_bit;
	logic word_full;

	// ==============================
	// combinational read and lowest-zero encode
	// ==============================

	assign rd_word = map_mem[word_idx];
	assign word_full = &rd_word;
	assign idx_o = {word_idx, bit_idx};

	// scan from the top down so the lowest zero is the last one kept
	always_comb
	begin
		zero_bit = '0;
		for (int i = pam_geom_pkg::WORD_BITS - 1; i >= 0; i--)
		begin
			if (!rd_word[i])
				zero_bit = i[pam_geom_pkg::BIT_IDX_BITS-1:0];
		end
	end

	// one-hot mask of the bit a free is going to clear
	always_comb
	begin
		bit_mask = '0;
		bit_mask[bit_idx] = 1'b1;
	end

	// ==============================
	// state machine
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= pam_ctrl_pkg::BS_IDLE;
			ready_o <= 1'b0;
			found_o <= 1'b0;
			word_idx <= '0;
		end
		else
		begin
			ready_o <= 1'b0;
			case (state)
				pam_ctrl_pkg::BS_IDLE:
				begin
					if (clear_i)
					begin
						word_idx <= '0;
						state <= pam_ctrl_pkg::BS_CLEAR;
					end
					else if (search_i)
					begin
						word_idx <= '0;
						state <= pam_ctrl_pkg::BS_SEARCH;
					end
					else if (free_i)
					begin
						word_idx <= free_idx_i[pam_geom_pkg::WORD_IDX_BITS+pam_geom_pkg::BIT_IDX_BITS-1:
							pam_geom_pkg::BIT_IDX_BITS];
						state <= pam_ctrl_pkg::BS_FREE_RD;
					end
				end
				pam_ctrl_pkg::BS_CLEAR:
				begin
					// the counter wraps back to zero after the last word
					word_idx <= word_idx + 1'b1;
					if (&word_idx)
					begin
						ready_o <= 1'b1;
						state <= pam_ctrl_pkg::BS_IDLE;
					end
				end
				pam_ctrl_pkg::BS_SEARCH:
				begin
					if (!word_full)
					begin
						// keep word_idx so a later commit writes this word
						ready_o <= 1'b1;
						found_o <= 1'b1;
						state <= pam_ctrl_pkg::BS_HOLD;
					end
					else if (&word_idx)
					begin
						ready_o <= 1'b1;
						found_o <= 1'b0;
						state <= pam_ctrl_pkg::BS_IDLE;
					end
					else
						word_idx <= word_idx + 1'b1;
				end
				pam_ctrl_pkg::BS_HOLD:
				begin
					if (commit_i)
						state <= pam_ctrl_pkg::BS_WRITE;
					else if (hold_release_i)
						state <= pam_ctrl_pkg::BS_IDLE;
				end
				pam_ctrl_pkg::BS_FREE_RD:
					state <= pam_ctrl_pkg::BS_WRITE;
				pam_ctrl_pkg::BS_WRITE:
				begin
					ready_o <= 1'b1;
					state <= pam_ctrl_pkg::BS_IDLE;
				end
				default:
					state <= pam_ctrl_pkg::BS_IDLE;
			endcase
		end
	end

	// ==============================
	// map and working word
	// ==============================

	always_ff @(posedge clk)
	begin
		case (state)
			pam_ctrl_pkg::BS_IDLE:
			begin
				if (free_i)
					bit_idx <= free_idx_i[pam_geom_pkg::BIT_IDX_BITS-1:0];
			end
			pam_ctrl_pkg::BS_CLEAR:
				map_mem[word_idx] <= '0;
			pam_ctrl_pkg::BS_SEARCH:
			begin
				if (!word_full)
				begin
					work <= rd_word;
					bit_idx <= zero_bit;
				end
			end
			pam_ctrl_pkg::BS_HOLD:
			begin
				if (commit_i)
					work[bit_idx] <= 1'b1;
			end
			// read half of the free, the page bit drops on the way in
			pam_ctrl_pkg::BS_FREE_RD:
				work <= rd_word & ~bit_mask;
			pam_ctrl_pkg::BS_WRITE:
				map_mem[word_idx] <= work;
			default:
			begin
			end
		endcase
	end

endmodule

// File: hw/pam_select.sv
// ==============================
// command front end, strobes arriving while busy_o is high are dropped
// priority is clear all, then free, then allocate
// a clear of both banks starts by itself right after reset
// ==============================

module pam_select
(
	input  logic clk,
	input  logic rst,
	input  logic alloc_i,
	input  logic free_i,
	input  logic clearall_i,
	input  logic [pam_geom_pkg::PAGE_BITS-1:0] page_i,
	output logic busy_o,
	output logic done_o,
	output logic fail_o,
	output logic [pam_geom_pkg::PAGE_BITS-1:0] page_o,
	output logic lo_clear_o,
	output logic lo_search_o,
	output logic lo_commit_o,
	output logic lo_hold_release_o,
	output logic lo_free_o,
	output logic [pam_geom_pkg::PAGE_BITS-2:0] lo_free_idx_o,
	input  logic lo_ready_i,
	input  logic lo_found_i,
	input  logic [pam_geom_pkg::PAGE_BITS-2:0] lo_idx_i,
	output logic hi_clear_o,
	output logic hi_search_o,
	output logic hi_commit_o,
	output logic hi_hold_release_o,
	output logic hi_free_o,
	output logic [pam_geom_pkg::PAGE_BITS-2:0] hi_free_idx_o,
	input  logic hi_ready_i,
	input  logic hi_found_i,
	input  logic [pam_geom_pkg::PAGE_BITS-2:0] hi_idx_i
);

	pam_ctrl_pkg::pam_op_e op;

	// set by reset so the first idle cycle starts the clear
	logic boot;
	// allocate has passed the search and waits for the write
	logic committing;
	// the high bank won the allocate
	logic win_hi;
	// ready already seen from each bank for the current order
	logic lo_rdy;
	logic hi_rdy;
	logic lo_found_q;
	logic hi_found_q;
	logic lo_seen;
	logic hi_seen;
	logic win_ready;
	logic page_hi;
	logic [pam_geom_pkg::PAGE_BITS-2:0] free_idx_q;

	// a ready in this cycle counts too, so free ends one cycle after the bank
	assign lo_seen = lo_rdy | lo_ready_i;
	assign hi_seen = hi_rdy | hi_ready_i;
	assign win_ready = win_hi ? hi_ready_i : lo_ready_i;
	assign page_hi = page_i[pam_geom_pkg::PAGE_BITS-1];

	// both banks see the same index, only one gets the free strobe
	assign lo_free_idx_o = free_idx_q;
	assign hi_free_idx_o = free_idx_q;

	always_ff @(posedge clk)
	begin
		if (free_i && !busy_o)
			free_idx_q <= page_i[pam_geom_pkg::PAGE_BITS-2:0];
	end

	// the bank index stays on idx while its write completes
	always_ff @(posedge clk)
	begin
		if (committing && win_ready)
			page_o <= win_hi ? pam_geom_pkg::BANK_PAGES + {1'b0, hi_idx_i} : {1'b0, lo_idx_i};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op <= pam_ctrl_pkg::OP_NONE;
			boot <= 1'b1;
			busy_o <= 1'b0;
			done_o <= 1'b0;
			fail_o <= 1'b0;
			committing <= 1'b0;
			win_hi <= 1'b0;
			lo_rdy <= 1'b0;
			hi_rdy <= 1'b0;
			lo_found_q <= 1'b0;
			hi_found_q <= 1'b0;
			{lo_clear_o, lo_search_o, lo_commit_o, lo_hold_release_o, lo_free_o} <= '0;
			{hi_clear_o, hi_search_o, hi_commit_o, hi_hold_release_o, hi_free_o} <= '0;
		end
		else
		begin
			// orders and done are single-cycle pulses
			{lo_clear_o, lo_search_o, lo_commit_o, lo_hold_release_o, lo_free_o} <= '0;
			{hi_clear_o, hi_search_o, hi_commit_o, hi_hold_release_o, hi_free_o} <= '0;
			done_o <= 1'b0;
			fail_o <= 1'b0;

			// ==============================
			// command latch
			// ==============================
			if (!busy_o)
			begin
				lo_rdy <= 1'b0;
				hi_rdy <= 1'b0;
				committing <= 1'b0;
				if (boot || clearall_i)
				begin
					op <= pam_ctrl_pkg::OP_CLEAR;
					boot <= 1'b0;
					busy_o <= 1'b1;
					lo_clear_o <= 1'b1;
					hi_clear_o <= 1'b1;
				end
				else if (free_i)
				begin
					// the untouched bank counts as ready from the start
					op <= pam_ctrl_pkg::OP_FREE;
					busy_o <= 1'b1;
					lo_free_o <= !page_hi;
					hi_free_o <= page_hi;
					lo_rdy <= page_hi;
					hi_rdy <= !page_hi;
				end
				else if (alloc_i)
				begin
					op <= pam_ctrl_pkg::OP_ALLOC;
					busy_o <= 1'b1;
					lo_search_o <= 1'b1;
					hi_search_o <= 1'b1;
				end
			end
			else
			begin
				if (lo_ready_i)
				begin
					lo_rdy <= 1'b1;
					lo_found_q <= lo_found_i;
				end
				if (hi_ready_i)
				begin
					hi_rdy <= 1'b1;
					hi_found_q <= hi_found_i;
				end

				// ==============================
				// completion and bank choice
				// ==============================
				case (op)
					pam_ctrl_pkg::OP_ALLOC:
					begin
						if (committing)
						begin
							if (win_ready)
							begin
								done_o <= 1'b1;
								busy_o <= 1'b0;
								op <= pam_ctrl_pkg::OP_NONE;
							end
						end
						else if (lo_rdy && hi_rdy)
						begin
							// the low bank holds lower pages, so it wins whenever it has one
							lo_rdy <= 1'b0;
							hi_rdy <= 1'b0;
							if (lo_found_q)
							begin
								lo_commit_o <= 1'b1;
								hi_hold_release_o <= 1'b1;
								win_hi <= 1'b0;
								committing <= 1'b1;
							end
							else if (hi_found_q)
							begin
								hi_commit_o <= 1'b1;
								lo_hold_release_o <= 1'b1;
								win_hi <= 1'b1;
								committing <= 1'b1;
							end
							else
							begin
								// map is full, page_o keeps its old value
								lo_hold_release_o <= 1'b1;
								hi_hold_release_o <= 1'b1;
								done_o <= 1'b1;
								fail_o <= 1'b1;
								busy_o <= 1'b0;
								op <= pam_ctrl_pkg::OP_NONE;
							end
						end
					end
					pam_ctrl_pkg::OP_CLEAR, pam_ctrl_pkg::OP_FREE:
					begin
						if (lo_seen && hi_seen)
						begin
							done_o <= 1'b1;
							busy_o <= 1'b0;
							op <= pam_ctrl_pkg::OP_NONE;
						end
					end
					default:
						busy_o <= 1'b0;
				endcase
			end
		end
	end

endmodule

// File: hw/page_alloc_top.sv
// ==============================
// page allocation map for 16384 pages, low bank below high bank
// commands are one-cycle strobes, taken only while busy_o is low
// ==============================

module page_alloc_top
(
	input  logic clk,
	input  logic rst,
	input  logic alloc_i,
	input  logic free_i,
	input  logic clearall_i,
	input  logic [pam_geom_pkg::PAGE_BITS-1:0] page_i,
	output logic busy_o,
	output logic done_o,
	output logic fail_o,
	output logic [pam_geom_pkg::PAGE_BITS-1:0] page_o
);

	// order and result lines between the selector and the low bank
	logic lo_clear;
	logic lo_search;
	logic lo_commit;
	logic lo_hold_release;
	logic lo_free;
	logic [pam_geom_pkg::PAGE_BITS-2:0] lo_free_idx;
	logic lo_ready;
	logic lo_found;
	logic [pam_geom_pkg::PAGE_BITS-2:0] lo_idx;

	// same set for the high bank
	logic hi_clear;
	logic hi_search;
	logic hi_commit;
	logic hi_hold_release;
	logic hi_free;
	logic [pam_geom_pkg::PAGE_BITS-2:0] hi_free_idx;
	logic hi_ready;
	logic hi_found;
	logic [pam_geom_pkg::PAGE_BITS-2:0] hi_idx;

	pam_select sel_i
	(
		.clk(clk),
		.rst(rst),
		.alloc_i(alloc_i),
		.free_i(free_i),
		.clearall_i(clearall_i),
		.page_i(page_i),
		.busy_o(busy_o),
		.done_o(done_o),
		.fail_o(fail_o),
		.page_o(page_o),
		.lo_clear_o(lo_clear),
		.lo_search_o(lo_search),
		.lo_commit_o(lo_commit),
		.lo_hold_release_o(lo_hold_release),
		.lo_free_o(lo_free),
		.lo_free_idx_o(lo_free_idx),
		.lo_ready_i(lo_ready),
		.lo_found_i(lo_found),
		.lo_idx_i(lo_idx),
		.hi_clear_o(hi_clear),
		.hi_search_o(hi_search),
		.hi_commit_o(hi_commit),
		.hi_hold_release_o(hi_hold_release),
		.hi_free_o(hi_free),
		.hi_free_idx_o(hi_free_idx),
		.hi_ready_i(hi_ready),
		.hi_found_i(hi_found),
		.hi_idx_i(hi_idx)
	);

	// pages 0 to 8191
	pam_bank bank_lo_i
	(
		.clk(clk),
		.rst(rst),
		.clear_i(lo_clear),
		.search_i(lo_search),
		.commit_i(lo_commit),
		.hold_release_i(lo_hold_release),
		.free_i(lo_free),
		.free_idx_i(lo_free_idx),
		.ready_o(lo_ready),
		.found_o(lo_found),
		.idx_o(lo_idx)
	);

	// pages 8192 to 16383
	pam_bank bank_hi_i
	(
		.clk(clk),
		.rst(rst),
		.clear_i(hi_clear),
		.search_i(hi_search),
		.commit_i(hi_commit),
		.hold_release_i(hi_hold_release),
		.free_i(hi_free),
		.free_idx_i(hi_free_idx),
		.ready_o(hi_ready),
		.found_o(hi_found),
		.idx_o(hi_idx)
	);

endmodule

// File: bench/page_alloc_asserts.sv
// ==============================
// protocol checks on the selector outputs
// bound into every pam_select instance
// ==============================

module page_alloc_asserts
(
	input  logic clk,
	input  logic rst,
	input  logic busy_o,
	input  logic done_o,
	input  logic fail_o,
	input  logic lo_commit_o,
	input  logic hi_commit_o
);

	// done_o is raised by the same edge that drops busy_o
	assert property (@(posedge clk) disable iff (rst) $rose(done_o) |-> $past(busy_o))
		else $error("done_o rose while no command was running");

	// only one bank may take the page
	assert property (@(posedge clk) disable iff (rst) !(lo_commit_o && hi_commit_o))
		else $error("commit sent to both banks in one cycle");

	assert property (@(posedge clk) disable iff (rst) fail_o |-> done_o)
		else $error("fail_o high without done_o");

endmodule

bind pam_select page_alloc_asserts asserts_i
(
	.clk(clk),
	.rst(rst),
	.busy_o(busy_o),
	.done_o(done_o),
	.fail_o(fail_o),
	.lo_commit_o(lo_commit_o),
	.hi_commit_o(hi_commit_o)
);

// File: bench/tb_page_alloc.sv
// ==============================
// table-driven testbench for page_alloc_top, inputs change on the falling edge
// expected pages come from a bitmap model of all 16384 pages
// the first error stops the run
// ==============================

module tb_page_alloc;

	// row opcodes of the stimulus table, a random free picks its own page
	typedef enum logic [1:0]
	{
		T_ALLOC,
		T_FREE,
		T_FREE_RND,
		T_CLEAR
	} step_op_e;

	typedef struct packed
	{
		step_op_e op;
		logic [pam_geom_pkg::PAGE_BITS-1:0] page;
		logic [15:0] count;
	} step_t;

	localparam int TIMEOUT = 20000;
	localparam int NUM_PAGES = 16384;
	localparam int NUM_STEPS = 20;

	// the fill steps are sized so the whole map is in use before the fail rows
	step_t steps [NUM_STEPS] = '{
		'{T_ALLOC, 14'd0, 16'd100},
		'{T_FREE, 14'd37, 16'd1},
		'{T_ALLOC, 14'd0, 16'd1},
		'{T_FREE_RND, 14'd0, 16'd20},
		'{T_ALLOC, 14'd0, 16'd25},
		'{T_CLEAR, 14'd0, 16'd1},
		'{T_ALLOC, 14'd0, 16'd8192},
		'{T_ALLOC, 14'd0, 16'd1},
		'{T_FREE, 14'd5000, 16'd1},
		'{T_ALLOC, 14'd0, 16'd1},
		'{T_ALLOC, 14'd0, 16'd8191},
		'{T_ALLOC, 14'd0, 16'd2},
		'{T_FREE, 14'd12000, 16'd1},
		'{T_ALLOC, 14'd0, 16'd1},
		'{T_CLEAR, 14'd0, 16'd1},
		'{T_ALLOC, 14'd0, 16'd1},
		'{T_FREE, 14'd200, 16'd1},
		'{T_ALLOC, 14'd0, 16'd3},
		'{T_FREE_RND, 14'd0, 16'd10},
		'{T_ALLOC, 14'd0, 16'd5}
	};

	logic clk;
	logic rst;
	logic alloc_i;
	logic free_i;
	logic clearall_i;
	logic [pam_geom_pkg::PAGE_BITS-1:0] page_i;
	logic busy_o;
	logic done_o;
	logic fail_o;
	logic [pam_geom_pkg::PAGE_BITS-1:0] page_o;

	// reference map, a set bit means the page is in use
	bit used_map [NUM_PAGES];
	logic [31:0] rnd_state;
	logic [pam_geom_pkg::PAGE_BITS-1:0] rnd_page;

	page_alloc_top dut_i
	(
		.clk(clk),
		.rst(rst),
		.alloc_i(alloc_i),
		.free_i(free_i),
		.clearall_i(clearall_i),
		.page_i(page_i),
		.busy_o(busy_o),
		.done_o(done_o),
		.fail_o(fail_o),
		.page_o(page_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// model and compare helpers
	// ==============================

	// full 32-bit linear congruential step
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// lowest page not in use, or -1 when the model is full
	function automatic int lowest_free();
		for (int p = 0; p < NUM_PAGES; p++)
		begin
			if (!used_map[p])
				return p;
		end
		return -1;
	endfunction

	task automatic check_page(input logic [pam_geom_pkg::PAGE_BITS-1:0] got,
		input logic [pam_geom_pkg::PAGE_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("mismatch page_o got %h expected %h", got, exp);
			$display("TB FAILED");
			$fatal(1, "page number check failed");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "flag check failed");
		end
	endtask

	// returns at the falling edge where done_o is seen high
	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done_o)
		begin
			if (cycles >= TIMEOUT)
			begin
				$display("done_o did not arrive within %0d cycles", TIMEOUT);
				$display("TB FAILED");
				$fatal(1, "timeout while waiting for done_o");
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// one strobe, wait for done_o, then compare against the model and update it
	task automatic run_cmd(input step_op_e op, input logic [pam_geom_pkg::PAGE_BITS-1:0] page);
		int lowest;
		lowest = lowest_free();
		alloc_i = (op == T_ALLOC);
		free_i = (op == T_FREE) || (op == T_FREE_RND);
		clearall_i = (op == T_CLEAR);
		page_i = page;
		@(negedge clk);
		alloc_i = 1'b0;
		free_i = 1'b0;
		clearall_i = 1'b0;
		// the command was taken at the rising edge just passed
		check_flag("busy_o", busy_o, 1'b1);
		wait_done();
		// busy_o drops together with the done_o pulse
		check_flag("busy_o", busy_o, 1'b0);
		if (op == T_ALLOC && lowest < 0)
		begin
			// a full map must fail and stay as it is
			check_flag("fail_o", fail_o, 1'b1);
		end
		else if (op == T_ALLOC)
		begin
			check_flag("fail_o", fail_o, 1'b0);
			check_page(page_o, lowest[pam_geom_pkg::PAGE_BITS-1:0]);
			used_map[lowest] = 1'b1;
		end
		else if (op == T_CLEAR)
		begin
			check_flag("fail_o", fail_o, 1'b0);
			for (int p = 0; p < NUM_PAGES; p++)
				used_map[p] = 1'b0;
		end
		else
		begin
			check_flag("fail_o", fail_o, 1'b0);
			used_map[page] = 1'b0;
		end
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial
	begin
		rst = 1'b1;
		alloc_i = 1'b0;
		free_i = 1'b0;
		clearall_i = 1'b0;
		page_i = '0;
		rnd_state = 32'd51748;
		for (int p = 0; p < NUM_PAGES; p++)
			used_map[p] = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// the clear after reset ends with its own done_o pulse
		wait_done();
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("fail_o", fail_o, 1'b0);
		for (int s = 0; s < NUM_STEPS; s++)
		begin
			for (int n = 0; n < int'(steps[s].count); n++)
			begin
				if (steps[s].op == T_FREE_RND)
				begin
					// random frees stay among the low pages, where most allocations are
					rnd_state = lcg_next(rnd_state);
					rnd_page = 14'((rnd_state >> 12) % 32'd100);
					run_cmd(steps[s].op, rnd_page);
				end
				else
					run_cmd(steps[s].op, steps[s].page);
			end
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: tb.f
hw/pam_geom_pkg.sv
hw/pam_ctrl_pkg.sv
hw/pam_bank.sv
hw/pam_select.sv
hw/page_alloc_top.sv
bench/page_alloc_asserts.sv
bench/tb_page_alloc.sv

// File: run.sh
#!/bin/sh
# build and run the page allocation map testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_page_alloc \
	-f tb.f -o Vtb_page_alloc

# the log decides the result, so a nonzero exit from the model is not fatal here
./obj_dir/Vtb_page_alloc > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result line, see sim.log"
	exit 1
fi
